/* dv/tb_sa_top.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// testbench for the measurement front end top
// spi tasks, reference functions, az compare
//////////////////////////////////////////////////

module tb_sa_top
  import sa_pkg::*;
();

  localparam int HALF_SCK = 4;         // clk per sck half, sck = clk/8
  localparam int WAIT_MAX = 4000;      // clk per wait loop

  logic        clk = 1'b0;
  logic        arst_n_i, sck_i, sdi_i, ss_n_i;
  logic        sdo_o;
  logic [3:0]  hw_flags_i;
  logic [3:0]  leds_o;
  logic [7:0]  monitor_o;
  logic [1:0]  sig_pc_sw_o;
  logic [3:0]  azmux_o;
  logic        meas_complete_o, spi_interrupt_o;
  logic [19:0] out_word;               // all board pins, pin map order

  integer      seed = 32'hf8c0e9fa;
  int          err_count = 0;
  int          timeout_count = 0;
  int          pulse_count = 0;
  int          pulses_before;
  int          cycle = 0;
  int          last_pulse = -1;
  int          prech, apert;
  logic        az_check = 1'b0;        // compare process enable
  logic        arm_seen = 1'b0;        // arm level as last written
  logic [23:0] rd_val, wdata;
  logic [6:0]  addr;
  logic [3:0]  az_lo, az_hi;
  logic [1:0]  pc_hi;

  always #2 clk = ~clk;                // 4 ns

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  assign out_word = {spi_interrupt_o, meas_complete_o, azmux_o, sig_pc_sw_o, monitor_o, leds_o};

  sa_top #(
    .COUNT_WIDTH (24)
  ) i_dut (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .sck_i           (sck_i),
    .sdi_i           (sdi_i),
    .ss_n_i          (ss_n_i),
    .sdo_o           (sdo_o),
    .hw_flags_i      (hw_flags_i),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .sig_pc_sw_o     (sig_pc_sw_o),
    .azmux_o         (azmux_o),
    .meas_complete_o (meas_complete_o),
    .spi_interrupt_o (spi_interrupt_o)
  );

  //////////////////////////////////////////////////
  // reference functions

  // count 23:16, spare 15, state 14:12, flags 11:8, magic 7:0
  function automatic logic [23:0] model_status(input logic [3:0] flags, input logic [2:0] st,
                                               input logic [7:0] cnt);
    return {cnt, 1'b0, st, flags, 8'hAA};
  endfunction

  // static modes only, direct bits map straight onto the pins
  function automatic logic [19:0] model_outputs(input mode_e mode, input logic [19:0] dir);
    logic [19:0] res;
    case (mode)
      MODE_DIRECT: res = dir;
      MODE_HI:     res = 20'hfffff;
      default:     res = 20'h00000;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // helpers
  task automatic check_val(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error: %s = 0x%06h, expected 0x%06h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic abort_run(input string what);
    timeout_count++;
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one 32 bit frame, sdo captured just before each data rise
  task automatic spi_frame(input logic wr, input logic [6:0] a, input logic [23:0] wd,
                           output logic [23:0] rd);
    logic [31:0] frame;
    frame = {wr, a, wd};
    rd = '0;
    @(negedge clk);
    ss_n_i = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      sck_i = 1'b0;
      sdi_i = frame[i];
      clocks(HALF_SCK);
      if (i < 24) begin
        rd[i] = sdo_o;
      end else if (sdo_o !== 1'b0) begin
        err_count++;
        $display("** Error: sdo_o = 0x%0h in header, expected 0x0 at %0t", sdo_o, $time);
      end
      sck_i = 1'b1;
      clocks(HALF_SCK);
    end
    sck_i = 1'b0;
    clocks(HALF_SCK);
    ss_n_i = 1'b1;
    sdi_i  = 1'b0;
    clocks(8);                         // write lands within 4 clk
  endtask

  task automatic reg_write(input logic [6:0] a, input logic [23:0] d);
    logic [23:0] ignored;
    spi_frame(1'b1, a, d, ignored);
  endtask

  task automatic reg_read(input logic [6:0] a, output logic [23:0] d);
    spi_frame(1'b0, a, 24'h0, d);
  endtask

  task automatic wait_pulses(input int target);
    int n;
    n = 0;
    while (pulse_count < target) begin
      if (n == WAIT_MAX) begin
        abort_run("meas_complete_o pulses");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (monitor_o[2:0] != SA_IDLE) begin
      if (n == WAIT_MAX) begin
        abort_run("the sequencer to go idle");
      end
      @(negedge clk);
      n++;
    end
  endtask

  //////////////////////////////////////////////////
  // az test compare, outputs sampled mid cycle
  always @(negedge clk) begin
    if (az_check) begin
      if (leds_o[3:1] !== 3'b000 || (arm_seen && leds_o[0] !== 1'b1)) begin
        err_count++;
        $display("** Error: leds_o = 0x%0h, expected 0x%0h at %0t", leds_o, arm_seen, $time);
      end
      if (sig_pc_sw_o == pc_hi && azmux_o !== az_hi) begin  // hi phase
        err_count++;
        $display("** Error: azmux_o = 0x%0h, expected 0x%0h at %0t", azmux_o, az_hi, $time);
      end
      if (monitor_o[2:0] == SA_IDLE && azmux_o !== az_lo) begin
        err_count++;
        $display("** Error: azmux_o = 0x%0h, expected 0x%0h at %0t", azmux_o, az_lo, $time);
      end
      if (meas_complete_o) begin
        pulse_count++;
        if (last_pulse >= 0 && (cycle - last_pulse) < (prech + 2 * apert)) begin
          err_count++;
          $display("measurement pulses only %0d clk apart at %0t", cycle - last_pulse, $time);
        end
        last_pulse = cycle;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  initial begin
    arst_n_i   = 1'b0;
    sck_i      = 1'b0;
    sdi_i      = 1'b0;
    ss_n_i     = 1'b1;
    hw_flags_i = 4'($random(seed));
    clocks(5);
    arst_n_i = 1'b1;
    clocks(2);

    // reset values
    check_val("out_word", 24'(out_word), 24'h0);
    check_val("sdo_o", 24'(sdo_o), 24'h0);
    reg_read(REG_STATUS, rd_val);
    check_val("status", rd_val, model_status(hw_flags_i, SA_IDLE, 8'h00));

    // read-write registers
    for (int a = 0; a <= 8; a++) begin
      if (a != REG_STATUS) begin
        wdata = 24'($random(seed));
        if (a == REG_ARM) begin
          wdata[0] = 1'b0;             // keep the sequencer idle
        end
        reg_write(7'(a), wdata);
        reg_read(7'(a), rd_val);
        check_val($sformatf("reg %0d", a), rd_val, wdata);
      end
    end
    addr = 7'(9 + ($random(seed) & 32'h3f));  // somewhere past the map
    reg_write(addr, 24'($random(seed)));
    reg_read(addr, rd_val);
    check_val($sformatf("reg %0d", addr), rd_val, 24'h0);
    reg_write(REG_STATUS, 24'($random(seed)));
    reg_read(REG_STATUS, rd_val);
    check_val("status", rd_val, model_status(hw_flags_i, SA_IDLE, 8'h00));

    // static modes
    reg_write(REG_MODE, 24'(MODE_LO));
    clocks(2);
    check_val("out_word", 24'(out_word), 24'(model_outputs(MODE_LO, 20'h0)));
    reg_write(REG_MODE, 24'(MODE_HI));
    clocks(2);
    check_val("out_word", 24'(out_word), 24'(model_outputs(MODE_HI, 20'h0)));
    reg_write(REG_MODE, 24'(MODE_DIRECT));
    repeat (4) begin
      wdata = 24'($random(seed));
      reg_write(REG_DIRECT, wdata);
      clocks(2);
      check_val("out_word", 24'(out_word), 24'(model_outputs(MODE_DIRECT, wdata[19:0])));
    end

    // az test, short timers
    prech = 5;
    apert = 3;
    az_lo = 4'($random(seed));
    az_hi = ~az_lo;
    pc_hi = 2'($random(seed)) | 2'b01;  // nonzero so hi phase is visible
    reg_write(REG_PRECHARGE, 24'(prech));
    reg_write(REG_APERTURE, 24'(apert));
    reg_write(REG_AZMUX_LO, 24'(az_lo));
    reg_write(REG_AZMUX_HI, 24'(az_hi));
    reg_write(REG_PC_HI, 24'(pc_hi));
    reg_write(REG_MODE, 24'(MODE_AZ_TEST));
    clocks(2);
    az_check = 1'b1;
    reg_write(REG_ARM, 24'h1);
    arm_seen = 1'b1;
    wait_pulses(pulse_count + 6);

    // disarm, current cycle may still finish
    arm_seen = 1'b0;
    reg_write(REG_ARM, 24'h0);
    pulses_before = pulse_count;
    wait_idle();
    clocks(4);
    if (pulse_count - pulses_before > 1) begin
      err_count++;
      $display("%0d measurement pulses after disarm", pulse_count - pulses_before);
    end
    check_val("sig_pc_sw_o", 24'(sig_pc_sw_o), 24'h0);
    check_val("azmux_o", 24'(azmux_o), 24'(az_lo));
    reg_read(REG_STATUS, rd_val);
    check_val("status", rd_val, model_status(hw_flags_i, SA_IDLE, 8'(pulse_count)));

    $display("errors: %0d, timeouts: %0d, pulses: %0d", err_count, timeout_count, pulse_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : tb_sa_top

`default_nettype wire

/* hdl/adc_mock.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// mock integrating adc
// valid pulse aperture + 1 clk after trigger
//////////////////////////////////////////////////

module adc_mock #(
  parameter int COUNT_WIDTH = 24
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   trig_i,
  input  logic [COUNT_WIDTH-1:0] aperture_i,    // aperture in clk
  output logic                   valid_o,
  output logic                   busy_o
);

  logic trig_q;                        // one clk setup before the aperture
  logic aperture_busy;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_q <= 1'b0;
    end else begin
      trig_q <= trig_i;
    end
  end

  clk_counter #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) i_aperture (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (trig_q),
    .value_i  (aperture_i),
    .busy_o   (aperture_busy),
    .done_o   (valid_o)               // end of aperture
  );

  assign busy_o = trig_q | aperture_busy;

  // sequencer must wait for valid before the next trigger
  a_trig_idle : assert property (
    @(posedge clk) disable iff (!arst_n_i) trig_i |-> !busy_o
  );

endmodule : adc_mock

`default_nettype wire

/* hdl/az_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// auto-zero acquisition fsm
// precharge, hi sample, lo sample, done
//////////////////////////////////////////////////

module az_sequencer
  import sa_pkg::*;
#(
  parameter int COUNT_WIDTH = 24
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   arm_i,
  input  logic                   adc_valid_i,
  input  logic [COUNT_WIDTH-1:0] precharge_i,   // precharge length in clk
  input  logic [3:0]             azmux_lo_i,
  input  logic [3:0]             azmux_hi_i,
  input  logic [1:0]             pc_hi_i,
  output logic [1:0]             sw_pc_o,
  output logic [3:0]             azmux_o,
  output logic                   adc_trig_o,
  output logic                   meas_complete_o,
  output sa_state_e              state_o,
  output logic [7:0]             sample_count_o
);

  sa_state_e  state_q, state_d;
  logic       pc_load, pc_done;
  logic       hi_phase;
  logic [7:0] count_q;

  // precharge timer
  clk_counter #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) i_pc_timer (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (pc_load),
    .value_i  (precharge_i),
    .busy_o   (),
    .done_o   (pc_done)
  );

  //////////////////////////////////////////////////
  // next state
  always_comb begin
    state_d = state_q;
    pc_load = 1'b0;
    case (state_q)
      SA_IDLE: begin
        if (arm_i) begin
          state_d = SA_PRECHARGE;
          pc_load = 1'b1;              // timer starts on entry
        end
      end
      SA_PRECHARGE: begin
        if (pc_done) begin
          state_d = SA_HI_TRIG;
        end
      end
      SA_HI_TRIG: state_d = SA_HI_WAIT;
      SA_HI_WAIT: begin
        if (adc_valid_i) begin
          state_d = SA_LO_TRIG;
        end
      end
      SA_LO_TRIG: state_d = SA_LO_WAIT;
      SA_LO_WAIT: begin
        if (adc_valid_i) begin
          state_d = SA_DONE;
        end
      end
      SA_DONE: begin
        // disarm only seen here
        if (arm_i) begin
          state_d = SA_PRECHARGE;
          pc_load = 1'b1;
        end else begin
          state_d = SA_IDLE;
        end
      end
      default: state_d = SA_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SA_IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SA_DONE) begin
        count_q <= count_q + 1'b1;     // wraps at 256
      end
    end
  end

  //////////////////////////////////////////////////
  // switch drive, decoded from state
  assign hi_phase = (state_q == SA_PRECHARGE) || (state_q == SA_HI_TRIG) ||
                    (state_q == SA_HI_WAIT);

  assign sw_pc_o         = hi_phase ? pc_hi_i : 2'b00;
  assign azmux_o         = hi_phase ? azmux_hi_i : azmux_lo_i;  // lo ref otherwise
  assign adc_trig_o      = (state_q == SA_HI_TRIG) || (state_q == SA_LO_TRIG);
  assign meas_complete_o = (state_q == SA_DONE);
  assign state_o         = state_q;
  assign sample_count_o  = count_q;

  // adc answers only while a wait state listens
  a_valid_in_wait : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    adc_valid_i |-> (state_q == SA_HI_WAIT || state_q == SA_LO_WAIT)
  );

endmodule : az_sequencer

`default_nettype wire

/* hdl/clk_counter.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// loadable down-counter with a done pulse
//////////////////////////////////////////////////

module clk_counter #(
  parameter int COUNT_WIDTH = 24
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   load_i,
  input  logic [COUNT_WIDTH-1:0] value_i,     // cycles until done
  output logic                   busy_o,
  output logic                   done_o
);

  logic [COUNT_WIDTH-1:0] cnt_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= (value_i == '0) ? COUNT_WIDTH'(1) : value_i;  // zero runs as one
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = (cnt_q != '0);
  assign done_o = (cnt_q == COUNT_WIDTH'(1));  // last count, N cycles after load

  // no reload of a running timer
  a_no_load_busy : assert property (
    @(posedge clk) disable iff (!arst_n_i) load_i |-> !busy_o
  );

endmodule : clk_counter

`default_nettype wire

/* hdl/output_mux.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// mode select for the board outputs, registered
//////////////////////////////////////////////////

module output_mux
  import sa_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  mode_e                mode_i,
  input  logic [OUT_WIDTH-1:0] direct_i,
  input  logic                 arm_i,
  input  sa_state_e            state_i,
  input  logic [7:0]           sample_count_i,
  input  logic [1:0]           sw_pc_i,
  input  logic [3:0]           azmux_i,
  input  logic                 meas_complete_i,
  output logic [3:0]           leds_o,
  output logic [7:0]           monitor_o,
  output logic [1:0]           sig_pc_sw_o,
  output logic [3:0]           azmux_o,
  output logic                 meas_complete_o,
  output logic                 spi_interrupt_o
);

  logic [OUT_WIDTH-1:0] sel_d, out_q;

  always_comb begin
    case (mode_i)
      MODE_DIRECT: sel_d = direct_i;
      MODE_LO:     sel_d = '0;
      MODE_HI:     sel_d = '1;
      MODE_AZ_TEST: begin
        sel_d = {1'b0,                 // spi_interrupt 19
                 meas_complete_i,      // 18
                 azmux_i,              // 17:14
                 sw_pc_i,              // 13:12
                 sample_count_i[3:0],  // monitor 7:4
                 1'b0,
                 state_i,              // monitor 2:0
                 3'b000,
                 arm_i};               // leds 0
      end
      default:     sel_d = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q <= '0;
    end else begin
      out_q <= sel_d;
    end
  end

  // pin map, leds and monitor in the low bits
  assign {spi_interrupt_o, meas_complete_o, azmux_o, sig_pc_sw_o, monitor_o, leds_o} = out_q;

endmodule : output_mux

`default_nettype wire

/* hdl/sa_pkg.sv */
`default_nettype none
//////////////////////////////////////////////////
// shared constants for the measurement front end
// register map, output modes, sequencer states
//////////////////////////////////////////////////

package sa_pkg;

  localparam int REG_WIDTH = 24;       // every register and the spi data phase
  localparam int OUT_WIDTH = 20;       // board outputs, same as the direct bits
  localparam logic [7:0] MAGIC = 8'hAA;  // low byte of status

  // spi register addresses
  typedef enum logic [6:0] {
    REG_MODE      = 7'd0,
    REG_DIRECT    = 7'd1,
    REG_STATUS    = 7'd2,              // read only
    REG_ARM       = 7'd3,              // bit 0 is the arm level
    REG_PRECHARGE = 7'd4,
    REG_AZMUX_LO  = 7'd5,
    REG_AZMUX_HI  = 7'd6,
    REG_PC_HI     = 7'd7,
    REG_APERTURE  = 7'd8
  } reg_addr_e;

  // output mode select
  typedef enum logic [1:0] {
    MODE_DIRECT,                       // register drives pins
    MODE_LO,
    MODE_HI,
    MODE_AZ_TEST                       // sequencer drives pins
  } mode_e;

  // auto-zero sequencer
  typedef enum logic [2:0] {
    SA_IDLE,
    SA_PRECHARGE,
    SA_HI_TRIG,
    SA_HI_WAIT,
    SA_LO_TRIG,
    SA_LO_WAIT,
    SA_DONE
  } sa_state_e;

endpackage : sa_pkg

`default_nettype wire

/* hdl/sa_top.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// measurement front end top
// spi registers, az sequencer, mock adc, outputs
//////////////////////////////////////////////////

module sa_top
  import sa_pkg::*;
#(
  parameter int COUNT_WIDTH = 24       // not wider than REG_WIDTH
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       ss_n_i,
  output logic       sdo_o,
  input  logic [3:0] hw_flags_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] sig_pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       meas_complete_o,
  output logic       spi_interrupt_o
);

  logic [REG_WIDTH-1:0] reg_mode, reg_direct, reg_precharge, reg_aperture;
  logic [REG_WIDTH-1:0] reg_azmux_lo, reg_azmux_hi, reg_pc_hi;
  logic [REG_WIDTH-1:0] status;
  logic                 arm;
  mode_e                mode;

  logic                 adc_trig, adc_valid;
  logic [1:0]           sa_sw_pc;
  logic [3:0]           sa_azmux;
  logic                 sa_meas_complete;
  sa_state_e            sa_state;
  logic [7:0]           sa_count;

  // count, spare, state, flags, magic
  assign status = {sa_count, 1'b0, sa_state, hw_flags_i, MAGIC};
  assign mode   = mode_e'(reg_mode[1:0]);

  spi_reg_bank i_reg_bank (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .sck_i       (sck_i),
    .sdi_i       (sdi_i),
    .ss_n_i      (ss_n_i),
    .sdo_o       (sdo_o),
    .status_i    (status),
    .mode_o      (reg_mode),
    .direct_o    (reg_direct),
    .arm_o       (arm),
    .precharge_o (reg_precharge),
    .azmux_lo_o  (reg_azmux_lo),
    .azmux_hi_o  (reg_azmux_hi),
    .pc_hi_o     (reg_pc_hi),
    .aperture_o  (reg_aperture)
  );

  az_sequencer #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) i_sequencer (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .arm_i           (arm),
    .adc_valid_i     (adc_valid),
    .precharge_i     (reg_precharge[COUNT_WIDTH-1:0]),
    .azmux_lo_i      (reg_azmux_lo[3:0]),
    .azmux_hi_i      (reg_azmux_hi[3:0]),
    .pc_hi_i         (reg_pc_hi[1:0]),
    .sw_pc_o         (sa_sw_pc),
    .azmux_o         (sa_azmux),
    .adc_trig_o      (adc_trig),
    .meas_complete_o (sa_meas_complete),
    .state_o         (sa_state),
    .sample_count_o  (sa_count)
  );

  adc_mock #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) i_adc (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .trig_i     (adc_trig),
    .aperture_i (reg_aperture[COUNT_WIDTH-1:0]),
    .valid_o    (adc_valid),
    .busy_o     ()
  );

  output_mux i_out_mux (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .mode_i          (mode),
    .direct_i        (reg_direct[OUT_WIDTH-1:0]),
    .arm_i           (arm),
    .state_i         (sa_state),
    .sample_count_i  (sa_count),
    .sw_pc_i         (sa_sw_pc),
    .azmux_i         (sa_azmux),
    .meas_complete_i (sa_meas_complete),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .sig_pc_sw_o     (sig_pc_sw_o),
    .azmux_o         (azmux_o),
    .meas_complete_o (meas_complete_o),
    .spi_interrupt_o (spi_interrupt_o)
  );

endmodule : sa_top

`default_nettype wire

/* hdl/spi_reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////////////////////////
// spi slave, oversampled on clk
// register file, read-back shifter, arm level
//////////////////////////////////////////////////

module spi_reg_bank
  import sa_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 sck_i,
  input  logic                 sdi_i,
  input  logic                 ss_n_i,
  output logic                 sdo_o,
  input  logic [REG_WIDTH-1:0] status_i,
  output logic [REG_WIDTH-1:0] mode_o,
  output logic [REG_WIDTH-1:0] direct_o,
  output logic                 arm_o,
  output logic [REG_WIDTH-1:0] precharge_o,
  output logic [REG_WIDTH-1:0] azmux_lo_o,
  output logic [REG_WIDTH-1:0] azmux_hi_o,
  output logic [REG_WIDTH-1:0] pc_hi_o,
  output logic [REG_WIDTH-1:0] aperture_o
);

  localparam int FRAME_BITS = 32;      // 1 write flag, 7 addr, 24 data

  logic [2:0]            sck_sr;       // 2 sync flops + edge history
  logic [2:0]            ss_sr;
  logic [1:0]            sdi_sr;
  logic                  sck_rise, sck_fall, ss_s, ss_rise;
  logic [5:0]            bit_cnt;
  logic [FRAME_BITS-1:0] shift_q;      // incoming frame
  logic [REG_WIDTH-1:0]  rd_shift;     // outgoing data
  logic [REG_WIDTH-1:0]  rd_data;
  logic [6:0]            hdr_addr;
  logic                  hdr_done, rd_step, wr_commit;
  logic                  sdo_q;
  logic [REG_WIDTH-1:0]  reg_arm;

  //////////////////////////////////////////////////
  // sync and edge detect
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_sr <= 3'b000;                // sck idles low
      ss_sr  <= 3'b111;                // deselected
      sdi_sr <= 2'b00;
    end else begin
      sck_sr <= {sck_sr[1:0], sck_i};
      ss_sr  <= {ss_sr[1:0], ss_n_i};
      sdi_sr <= {sdi_sr[0], sdi_i};
    end
  end

  assign sck_rise = sck_sr[1] & ~sck_sr[2];
  assign sck_fall = ~sck_sr[1] & sck_sr[2];
  assign ss_s     = ss_sr[1];
  assign ss_rise  = ss_sr[1] & ~ss_sr[2];  // end of frame

  assign hdr_addr  = {shift_q[5:0], sdi_sr[1]};  // addr complete on the 8th rise
  assign hdr_done  = !ss_s && sck_rise && (bit_cnt == 6'd7);
  assign rd_step   = !ss_s && sck_fall && (bit_cnt >= 6'd8) && (bit_cnt < 6'd32);
  assign wr_commit = ss_rise && (bit_cnt == 6'd32) && shift_q[31];

  //////////////////////////////////////////////////
  // frame shifters
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt <= '0;
      sdo_q   <= 1'b0;
    end else if (ss_s) begin
      bit_cnt <= '0;
      sdo_q   <= 1'b0;                 // low outside a frame
    end else begin
      if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (sck_fall) begin
        sdo_q <= rd_step ? rd_shift[REG_WIDTH-1] : 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!ss_s && sck_rise) begin
      shift_q <= {shift_q[FRAME_BITS-2:0], sdi_sr[1]};  // msb first
    end
    if (hdr_done) begin
      rd_shift <= rd_data;             // snapshot at end of header
    end else if (rd_step) begin
      rd_shift <= {rd_shift[REG_WIDTH-2:0], 1'b0};
    end
  end

  // read-back select
  always_comb begin
    case (reg_addr_e'(hdr_addr))
      REG_MODE:      rd_data = mode_o;
      REG_DIRECT:    rd_data = direct_o;
      REG_STATUS:    rd_data = status_i;
      REG_ARM:       rd_data = reg_arm;
      REG_PRECHARGE: rd_data = precharge_o;
      REG_AZMUX_LO:  rd_data = azmux_lo_o;
      REG_AZMUX_HI:  rd_data = azmux_hi_o;
      REG_PC_HI:     rd_data = pc_hi_o;
      REG_APERTURE:  rd_data = aperture_o;
      default:       rd_data = '0;    // unused addr
    endcase
  end

  //////////////////////////////////////////////////
  // register file, written when ss_n rises
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_o      <= '0;
      direct_o    <= '0;
      reg_arm     <= '0;
      precharge_o <= '0;
      azmux_lo_o  <= '0;
      azmux_hi_o  <= '0;
      pc_hi_o     <= '0;
      aperture_o  <= '0;
    end else if (wr_commit) begin
      case (reg_addr_e'(shift_q[30:24]))
        REG_MODE:      mode_o      <= shift_q[REG_WIDTH-1:0];
        REG_DIRECT:    direct_o    <= shift_q[REG_WIDTH-1:0];
        REG_ARM:       reg_arm     <= shift_q[REG_WIDTH-1:0];
        REG_PRECHARGE: precharge_o <= shift_q[REG_WIDTH-1:0];
        REG_AZMUX_LO:  azmux_lo_o  <= shift_q[REG_WIDTH-1:0];
        REG_AZMUX_HI:  azmux_hi_o  <= shift_q[REG_WIDTH-1:0];
        REG_PC_HI:     pc_hi_o     <= shift_q[REG_WIDTH-1:0];
        REG_APERTURE:  aperture_o  <= shift_q[REG_WIDTH-1:0];
        default: ;                     // status and unused ignore writes
      endcase
    end
  end

  assign arm_o = reg_arm[0];
  assign sdo_o = sdo_q;

  // master never clocks a 33rd bit
  a_frame_len : assert property (
    @(posedge clk) disable iff (!arst_n_i) (!ss_s && sck_rise) |-> (bit_cnt < 6'd32)
  );

endmodule : spi_reg_bank

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the sa_top testbench with verilator
# exit status 0 on pass, 1 on fail

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sa_top -f tb.f -o tb_sa_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_sa_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Result: FAILED" "$SIM_LOG"; then
  exit 1
fi
exit 0

/* tb.f */
hdl/sa_pkg.sv
hdl/clk_counter.sv
hdl/spi_reg_bank.sv
hdl/az_sequencer.sv
hdl/adc_mock.sv
hdl/output_mux.sv
hdl/sa_top.sv
dv/tb_sa_top.sv
